// File: sad_pkg.sv
/*
 * scaled-attention package
 * matrix sizes, element types and the frame schedule constants
 */
package sad_pkg;

    // ##############################
    // sizes
    localparam int DIM         = 8;
    localparam int MAX_T       = 8;
    // one 8x8 store, indexed row*8+col
    localparam int MAT_SIZE    = DIM * MAX_T;
    localparam int LOAD_CYCLES = 192;

    // determinant expansion runs right after the 4x4 matrix is in
    localparam int DET_START = 16;
    localparam int DET_TERMS = 24;
    localparam int CNT_W     = 10;

    // ##############################
    // element types
    typedef logic signed [5:0]  det_elem_t;
    typedef logic signed [7:0]  data_t;
    typedef logic signed [18:0] proj_t;
    // relu output, never negative
    typedef logic        [36:0] score_t;
    typedef logic signed [24:0] det_t;
    typedef logic signed [53:0] wsum_t;
    typedef logic signed [91:0] result_t;

    // indices and counts
    typedef logic [5:0]       idx_t;
    typedef logic [2:0]       row_t;
    typedef logic [3:0]       rows_t;
    typedef logic [4:0]       term_t;
    typedef logic [CNT_W-1:0] cnt_t;

    // matrix written by a projection step
    typedef enum logic [1:0] {
        SEL_Q,
        SEL_K,
        SEL_V
    } proj_sel_t;

endpackage

// File: sad_sequencer.sv
`timescale 1ns/10ps
/*
 * frame sequencer
 * counts the cycles of a frame, latches T in cycle 0 and turns the
 * count into load strobes, phase strobes and row/column indices
 */
module sad_sequencer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  sad_pkg::rows_t     t_rows,
    output sad_pkg::idx_t      load_idx,
    output logic               x_we,
    output logic               wq_we,
    output logic               wk_we,
    output logic               wv_we,
    output logic               det_we,
    output logic               det_step,
    output sad_pkg::term_t     det_term,
    output logic               proj_en,
    output sad_pkg::proj_sel_t proj_sel,
    output sad_pkg::row_t      proj_row,
    output sad_pkg::row_t      proj_col,
    output logic               score_en,
    output sad_pkg::row_t      score_row,
    output sad_pkg::row_t      score_col,
    output logic               out_en,
    output sad_pkg::row_t      out_row,
    output sad_pkg::row_t      out_col,
    output logic               frame_clear
);
    import sad_pkg::*;

    logic       busy;
    cnt_t       cnt;
    rows_t      t_reg;
    rows_t      t_cur;
    logic       load;
    logic [7:0] t_sq;
    cnt_t       t8;
    cnt_t       proj_end;
    cnt_t       score_end;
    cnt_t       out_end;
    cnt_t       det_off;
    cnt_t       proj_off;
    cnt_t       proj_ent;
    cnt_t       out_off;

    // ##############################
    // frame counter
    // cnt rests at 0 while idle, so the first burst cycle is cycle 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            cnt   <= '0;
            t_reg <= '0;
        end else if (!busy) begin
            if (in_valid) begin
                busy  <= 1'b1;
                cnt   <= cnt_t'(1);
                t_reg <= t_rows;
            end
        end else if (frame_clear) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else begin
            cnt <= cnt + cnt_t'(1);
        end
    end

    // ##############################
    // load strobes
    // T is not latched yet in cycle 0, take it straight from the port
    assign t_cur    = busy ? t_reg : t_rows;
    assign load     = (busy || in_valid) && cnt < cnt_t'(LOAD_CYCLES);
    assign load_idx = cnt[5:0];
    assign x_we     = load && cnt < cnt_t'({t_cur, 3'b000});
    assign wq_we    = load && cnt[7:6] == 2'd0;
    assign wk_we    = load && cnt[7:6] == 2'd1;
    assign wv_we    = load && cnt[7:6] == 2'd2;
    assign det_we   = load && cnt < cnt_t'(DET_START);

    // phase boundaries, all relative to cycle 0
    assign t8        = cnt_t'({t_reg, 3'b000});
    assign t_sq      = t_reg * t_reg;
    assign proj_end  = cnt_t'(LOAD_CYCLES) + t8 + (t8 << 1);
    assign score_end = proj_end + cnt_t'(t_sq);
    assign out_end   = score_end + t8;

    // one permutation term per cycle
    assign det_step = busy && cnt >= cnt_t'(DET_START)
                    && cnt < cnt_t'(DET_START + DET_TERMS);
    assign det_off  = cnt - cnt_t'(DET_START);
    assign det_term = det_off[4:0];

    // ##############################
    // projections: all of Q, then K, then V, 8T entries each
    assign proj_en  = busy && cnt >= cnt_t'(LOAD_CYCLES) && cnt < proj_end;
    assign proj_off = cnt - cnt_t'(LOAD_CYCLES);

    always_comb begin
        if (proj_off < t8) begin
            proj_sel = SEL_Q;
            proj_ent = proj_off;
        end else if (proj_off < (t8 << 1)) begin
            proj_sel = SEL_K;
            proj_ent = proj_off - t8;
        end else begin
            proj_sel = SEL_V;
            proj_ent = proj_off - (t8 << 1);
        end
    end

    assign proj_row = proj_ent[5:3];
    assign proj_col = proj_ent[2:0];

    // scores walk a TxT grid, so the indices step on their own
    assign score_en = busy && cnt >= proj_end && cnt < score_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            score_row <= '0;
            score_col <= '0;
        end else if (!score_en) begin
            score_row <= '0;
            score_col <= '0;
        end else if ({1'b0, score_col} == t_reg - 4'd1) begin
            score_col <= '0;
            score_row <= score_row + 3'd1;
        end else begin
            score_col <= score_col + 3'd1;
        end
    end

    // outputs, row-major over T rows and 8 columns
    assign out_en      = busy && cnt >= score_end && cnt < out_end;
    assign out_off     = cnt - score_end;
    assign out_row     = out_off[5:3];
    assign out_col     = out_off[2:0];
    assign frame_clear = busy && cnt == out_end;

endmodule

// File: sad_input_buf.sv
`timescale 1ns/10ps
/*
 * input storage
 * holds X and the three weight matrices, and reads one row of X and
 * one column of the selected weight matrix for the projection unit
 */
module sad_input_buf (
    input  logic               clk,
    input  logic               rst_n,
    input  sad_pkg::idx_t      load_idx,
    input  logic               x_we,
    input  logic               wq_we,
    input  logic               wk_we,
    input  logic               wv_we,
    input  logic               frame_clear,
    input  sad_pkg::data_t     in_data2,
    input  sad_pkg::data_t     w_q,
    input  sad_pkg::data_t     w_k,
    input  sad_pkg::data_t     w_v,
    input  sad_pkg::proj_sel_t proj_sel,
    input  sad_pkg::row_t      proj_row,
    input  sad_pkg::row_t      proj_col,
    output sad_pkg::data_t     x_row [sad_pkg::DIM],
    output sad_pkg::data_t     w_col [sad_pkg::DIM]
);
    import sad_pkg::*;

    data_t x_mem  [MAT_SIZE];
    data_t wq_mem [MAT_SIZE];
    data_t wk_mem [MAT_SIZE];
    data_t wv_mem [MAT_SIZE];

    // X is zeroed between frames, rows at T and above read as zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MAT_SIZE; i++) begin
                x_mem[i] <= '0;
            end
        end else if (frame_clear) begin
            for (int i = 0; i < MAT_SIZE; i++) begin
                x_mem[i] <= '0;
            end
        end else if (x_we) begin
            x_mem[load_idx] <= in_data2;
        end
    end

    // weights always arrive in full
    always_ff @(posedge clk) begin
        if (wq_we) begin
            wq_mem[load_idx] <= w_q;
        end
        if (wk_we) begin
            wk_mem[load_idx] <= w_k;
        end
        if (wv_we) begin
            wv_mem[load_idx] <= w_v;
        end
    end

    // column read of the row-major weights
    always_comb begin
        for (int k = 0; k < DIM; k++) begin
            x_row[k] = x_mem[{proj_row, 3'(k)}];
            case (proj_sel)
                SEL_Q:   w_col[k] = wq_mem[{3'(k), proj_col}];
                SEL_K:   w_col[k] = wk_mem[{3'(k), proj_col}];
                default: w_col[k] = wv_mem[{3'(k), proj_col}];
            endcase
        end
    end

endmodule

// File: sad_det.sv
`timescale 1ns/10ps
/*
 * 4x4 determinant
 * captures the matrix and adds one signed Leibniz term per step
 */
module sad_det (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               det_we,
    input  sad_pkg::idx_t      load_idx,
    input  sad_pkg::det_elem_t in_data1,
    input  logic               det_step,
    input  sad_pkg::term_t     det_term,
    input  logic               frame_clear,
    output sad_pkg::det_t      det
);
    import sad_pkg::*;

    // column picked in rows 0..3, two bits each, lexicographic order
    localparam logic [7:0] PERM [DET_TERMS] = '{
        8'h1b, 8'h1e, 8'h27, 8'h2d, 8'h36, 8'h39,
        8'h4b, 8'h4e, 8'h63, 8'h6c, 8'h72, 8'h78,
        8'h87, 8'h8d, 8'h93, 8'h9c, 8'hb1, 8'hb4,
        8'hc6, 8'hc9, 8'hd2, 8'hd8, 8'he1, 8'he4
    };

    det_elem_t          mat [16];
    logic [7:0]         perm;
    logic               neg;
    // four 6-bit factors, (-32)^4 needs 22 bits
    logic signed [21:0] term;

    always_ff @(posedge clk) begin
        if (det_we) begin
            mat[load_idx[3:0]] <= in_data1;
        end
    end

    // in lexicographic order the sign runs + - - + and repeats
    assign perm = PERM[det_term];
    assign neg  = det_term[0] ^ det_term[1];
    assign term = mat[{2'd0, perm[7:6]}] * mat[{2'd1, perm[5:4]}]
                * mat[{2'd2, perm[3:2]}] * mat[{2'd3, perm[1:0]}];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            det <= '0;
        end else if (frame_clear) begin
            det <= '0;
        end else if (det_step) begin
            if (neg) begin
                det <= det - term;
            end else begin
                det <= det + term;
            end
        end
    end

endmodule

// File: sad_projection.sv
`timescale 1ns/10ps
/*
 * Q/K/V projection
 * eight 8x8 products summed into one entry per cycle, stored in the
 * Q, K or V matrix, with read ports for the attention unit
 */
module sad_projection (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               proj_en,
    input  sad_pkg::proj_sel_t proj_sel,
    input  sad_pkg::row_t      proj_row,
    input  sad_pkg::row_t      proj_col,
    input  sad_pkg::data_t     x_row [sad_pkg::DIM],
    input  sad_pkg::data_t     w_col [sad_pkg::DIM],
    input  logic               frame_clear,
    input  sad_pkg::row_t      score_row,
    input  sad_pkg::row_t      score_col,
    input  sad_pkg::row_t      out_col,
    output sad_pkg::proj_t     q_row [sad_pkg::DIM],
    output sad_pkg::proj_t     k_row [sad_pkg::DIM],
    output sad_pkg::proj_t     v_col [sad_pkg::DIM]
);
    import sad_pkg::*;

    proj_t q_mem [MAT_SIZE];
    proj_t k_mem [MAT_SIZE];
    proj_t v_mem [MAT_SIZE];
    proj_t dot;
    idx_t  wr_idx;

    // eight products, each within 16 bits
    always_comb begin
        dot = '0;
        for (int k = 0; k < DIM; k++) begin
            dot = dot + x_row[k] * w_col[k];
        end
    end

    assign wr_idx = {proj_row, proj_col};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MAT_SIZE; i++) begin
                q_mem[i] <= '0;
                k_mem[i] <= '0;
                v_mem[i] <= '0;
            end
        end else if (frame_clear) begin
            for (int i = 0; i < MAT_SIZE; i++) begin
                q_mem[i] <= '0;
                k_mem[i] <= '0;
                v_mem[i] <= '0;
            end
        end else if (proj_en) begin
            case (proj_sel)
                SEL_Q:   q_mem[wr_idx] <= dot;
                SEL_K:   k_mem[wr_idx] <= dot;
                default: v_mem[wr_idx] <= dot;
            endcase
        end
    end

    // ##############################
    // read ports
    // K is read by row, which gives the transpose in Q.K^T for free
    always_comb begin
        for (int k = 0; k < DIM; k++) begin
            q_row[k] = q_mem[{score_row, 3'(k)}];
            k_row[k] = k_mem[{score_col, 3'(k)}];
            v_col[k] = v_mem[{3'(k), out_col}];
        end
    end

endmodule

// File: sad_attention.sv
`timescale 1ns/10ps
/*
 * attention scores and output
 * S = relu(Q.K^T)/3 stored per entry, then det * (S.V) through a
 * weighted-sum register and the output register
 */
module sad_attention (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             score_en,
    input  sad_pkg::row_t    score_row,
    input  sad_pkg::row_t    score_col,
    input  sad_pkg::proj_t   q_row [sad_pkg::DIM],
    input  sad_pkg::proj_t   k_row [sad_pkg::DIM],
    input  sad_pkg::det_t    det,
    input  logic             out_en,
    input  sad_pkg::row_t    out_row,
    input  sad_pkg::proj_t   v_col [sad_pkg::DIM],
    input  logic             frame_clear,
    output logic             out_valid,
    output sad_pkg::result_t out_data
);
    import sad_pkg::*;

    score_t             s_mem [MAT_SIZE];
    // eight 19x19 products, sum reaches 2^37
    logic signed [39:0] a_sum;
    score_t             s_new;
    wsum_t              p_sum;
    wsum_t              p_reg;
    logic               p_vld;

    // ##############################
    // scores
    always_comb begin
        a_sum = '0;
        for (int k = 0; k < DIM; k++) begin
            a_sum = a_sum + q_row[k] * k_row[k];
        end
    end

    // relu, then floor of a non-negative value over 3
    assign s_new = a_sum[39] ? '0 : score_t'(a_sum / 40'sd3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MAT_SIZE; i++) begin
                s_mem[i] <= '0;
            end
        end else if (frame_clear) begin
            for (int i = 0; i < MAT_SIZE; i++) begin
                s_mem[i] <= '0;
            end
        end else if (score_en) begin
            s_mem[{score_row, score_col}] <= s_new;
        end
    end

    // ##############################
    // weighted sum over V
    // S is unsigned, widen it by a zero bit before the signed product
    always_comb begin
        p_sum = '0;
        for (int k = 0; k < DIM; k++) begin
            p_sum = p_sum + $signed({1'b0, s_mem[{out_row, 3'(k)}]}) * v_col[k];
        end
    end

    always_ff @(posedge clk) begin
        if (out_en) begin
            p_reg <= p_sum;
        end
    end

    // output register, det scaling, zero outside the window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p_vld     <= 1'b0;
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            p_vld     <= out_en;
            out_valid <= p_vld;
            if (p_vld) begin
                out_data <= det * p_reg;
            end else begin
                out_data <= '0;
            end
        end
    end

endmodule

// File: sad_top.sv
`timescale 1ns/10ps
/*
 * determinant-weighted scaled attention, top level
 * connects the sequencer, input storage, determinant unit,
 * projection unit and attention unit
 */
module sad_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  sad_pkg::rows_t     t_rows,
    input  sad_pkg::det_elem_t in_data1,
    input  sad_pkg::data_t     in_data2,
    input  sad_pkg::data_t     w_q,
    input  sad_pkg::data_t     w_k,
    input  sad_pkg::data_t     w_v,
    output logic               out_valid,
    output sad_pkg::result_t   out_data
);

    // ##############################
    // strobes from the sequencer
    sad_pkg::idx_t      load_idx;
    logic               x_we;
    logic               wq_we;
    logic               wk_we;
    logic               wv_we;
    logic               det_we;
    logic               det_step;
    sad_pkg::term_t     det_term;
    logic               proj_en;
    sad_pkg::proj_sel_t proj_sel;
    sad_pkg::row_t      proj_row;
    sad_pkg::row_t      proj_col;
    logic               score_en;
    sad_pkg::row_t      score_row;
    sad_pkg::row_t      score_col;
    logic               out_en;
    sad_pkg::row_t      out_row;
    sad_pkg::row_t      out_col;
    logic               frame_clear;

    // datapath between the blocks
    sad_pkg::data_t x_row [sad_pkg::DIM];
    sad_pkg::data_t w_col [sad_pkg::DIM];
    sad_pkg::proj_t q_row [sad_pkg::DIM];
    sad_pkg::proj_t k_row [sad_pkg::DIM];
    sad_pkg::proj_t v_col [sad_pkg::DIM];
    sad_pkg::det_t  det;

    sad_sequencer sad_sequencer_inst (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .t_rows(t_rows),
        .load_idx(load_idx), .x_we(x_we), .wq_we(wq_we), .wk_we(wk_we),
        .wv_we(wv_we), .det_we(det_we), .det_step(det_step), .det_term(det_term),
        .proj_en(proj_en), .proj_sel(proj_sel), .proj_row(proj_row),
        .proj_col(proj_col), .score_en(score_en), .score_row(score_row),
        .score_col(score_col), .out_en(out_en), .out_row(out_row),
        .out_col(out_col), .frame_clear(frame_clear)
    );

    sad_input_buf sad_input_buf_inst (
        .clk(clk), .rst_n(rst_n), .load_idx(load_idx), .x_we(x_we),
        .wq_we(wq_we), .wk_we(wk_we), .wv_we(wv_we), .frame_clear(frame_clear),
        .in_data2(in_data2), .w_q(w_q), .w_k(w_k), .w_v(w_v),
        .proj_sel(proj_sel), .proj_row(proj_row), .proj_col(proj_col),
        .x_row(x_row), .w_col(w_col)
    );

    sad_det sad_det_inst (
        .clk(clk), .rst_n(rst_n), .det_we(det_we), .load_idx(load_idx),
        .in_data1(in_data1), .det_step(det_step), .det_term(det_term),
        .frame_clear(frame_clear), .det(det)
    );

    sad_projection sad_projection_inst (
        .clk(clk), .rst_n(rst_n), .proj_en(proj_en), .proj_sel(proj_sel),
        .proj_row(proj_row), .proj_col(proj_col), .x_row(x_row), .w_col(w_col),
        .frame_clear(frame_clear), .score_row(score_row), .score_col(score_col),
        .out_col(out_col), .q_row(q_row), .k_row(k_row), .v_col(v_col)
    );

    sad_attention sad_attention_inst (
        .clk(clk), .rst_n(rst_n), .score_en(score_en), .score_row(score_row),
        .score_col(score_col), .q_row(q_row), .k_row(k_row), .det(det),
        .out_en(out_en), .out_row(out_row), .v_col(v_col),
        .frame_clear(frame_clear), .out_valid(out_valid), .out_data(out_data)
    );

endmodule

// File: tb_sad.sv
`timescale 1ns/10ps
/*
 * testbench for the determinant-weighted attention core
 * random frames checked against a reference model
 */
module tb_sad;
    import sad_pkg::*;

    localparam int NUM_FRAMES     = 12;
    localparam int FRAME_LIMIT    = LOAD_CYCLES + 24 * MAX_T + 64 + 64 + 20;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_LIMIT;
    localparam int T_ORDER [8]    = '{8, 1, 6, 3, 7, 2, 5, 4};

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    rows_t     t_rows;
    det_elem_t in_data1;
    data_t     in_data2;
    data_t     w_q;
    data_t     w_k;
    data_t     w_v;
    logic      out_valid;
    result_t   out_data;

    // frame contents in row-major order
    int m_mat  [16];
    int x_mat  [MAT_SIZE];
    int wq_mat [MAT_SIZE];
    int wk_mat [MAT_SIZE];
    int wv_mat [MAT_SIZE];

    result_t exp_q [$];
    int      len_q [$];
    int      frames_done = 0;
    int      run_len     = 0;
    int      cycle_count = 0;

    sad_top sad_top_inst (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .t_rows(t_rows),
        .in_data1(in_data1), .in_data2(in_data2), .w_q(w_q), .w_k(w_k),
        .w_v(w_v), .out_valid(out_valid), .out_data(out_data)
    );

    always #10 clk = ~clk;

    // ##############################
    // error handling and checks
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_result(input string name, input result_t got, input result_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %0d expected %0d",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_count(input int frame, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("frame %0d gave %0d cycles of out_valid instead of %0d",
                               frame, got, exp));
        end
    endtask

    // ##############################
    // reference model
    function automatic int rand_signed(input int bits);
        return int'($urandom_range((1 << bits) - 1)) - (1 << (bits - 1));
    endfunction

    function automatic longint det3(input longint s [9]);
        return s[0] * (s[4] * s[8] - s[5] * s[7])
             - s[1] * (s[3] * s[8] - s[5] * s[6])
             + s[2] * (s[3] * s[7] - s[4] * s[6]);
    endfunction

    // cofactor expansion along row 0
    function automatic longint det4();
        longint sub [9];
        longint acc;
        int     n;
        acc = 0;
        for (int j = 0; j < 4; j++) begin
            n = 0;
            for (int r = 1; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    if (c != j) begin
                        sub[n] = m_mat[r * 4 + c];
                        n++;
                    end
                end
            end
            if (j % 2 == 0) begin
                acc += m_mat[j] * det3(sub);
            end else begin
                acc -= m_mat[j] * det3(sub);
            end
        end
        return acc;
    endfunction

    task automatic build_expected(input int t);
        longint  q [MAT_SIZE];
        longint  k [MAT_SIZE];
        longint  v [MAT_SIZE];
        longint  s [MAT_SIZE];
        longint  acc;
        det_t    d;
        wsum_t   p;
        result_t dw;
        result_t pw;
        d = det_t'(det4());
        for (int i = 0; i < t; i++) begin
            for (int c = 0; c < DIM; c++) begin
                q[i * DIM + c] = 0;
                k[i * DIM + c] = 0;
                v[i * DIM + c] = 0;
                for (int r = 0; r < DIM; r++) begin
                    q[i * DIM + c] += longint'(x_mat[i * DIM + r]) * wq_mat[r * DIM + c];
                    k[i * DIM + c] += longint'(x_mat[i * DIM + r]) * wk_mat[r * DIM + c];
                    v[i * DIM + c] += longint'(x_mat[i * DIM + r]) * wv_mat[r * DIM + c];
                end
            end
        end
        // relu, then floor division by 3
        for (int i = 0; i < t; i++) begin
            for (int j = 0; j < t; j++) begin
                acc = 0;
                for (int c = 0; c < DIM; c++) begin
                    acc += q[i * DIM + c] * k[j * DIM + c];
                end
                s[i * DIM + j] = (acc < 0) ? 0 : acc / 3;
            end
        end
        for (int i = 0; i < t; i++) begin
            for (int c = 0; c < DIM; c++) begin
                acc = 0;
                for (int j = 0; j < t; j++) begin
                    acc += s[i * DIM + j] * v[j * DIM + c];
                end
                p  = wsum_t'(acc);
                dw = d;
                pw = p;
                exp_q.push_back(dw * pw);
            end
        end
        len_q.push_back(8 * t);
    endtask

    // ##############################
    // frame contents
    task automatic fill_random();
        for (int i = 0; i < 16; i++) begin
            m_mat[i] = rand_signed(6);
        end
        for (int i = 0; i < MAT_SIZE; i++) begin
            x_mat[i]  = rand_signed(8);
            wq_mat[i] = rand_signed(8);
            wk_mat[i] = rand_signed(8);
            wv_mat[i] = rand_signed(8);
        end
    endtask

    // Q all positive and K all negative, so every score is below zero
    task automatic fill_relu();
        fill_random();
        for (int i = 0; i < MAT_SIZE; i++) begin
            x_mat[i]  = int'($urandom_range(127, 1));
            wq_mat[i] = int'($urandom_range(127, 1));
            wk_mat[i] = -int'($urandom_range(127, 1));
        end
    endtask

    // row 2 copies row 0 so det is zero
    task automatic make_rows_equal();
        for (int c = 0; c < 4; c++) begin
            m_mat[8 + c] = m_mat[c];
        end
    endtask

    // ##############################
    // stimulus
    task automatic drive_junk();
        in_data1 = det_elem_t'($urandom);
        in_data2 = data_t'($urandom);
        w_q      = data_t'($urandom);
        w_k      = data_t'($urandom);
        w_v      = data_t'($urandom);
    endtask

    task automatic run_frame(input int t, input bit toggle);
        for (int c = 0; c < LOAD_CYCLES; c++) begin
            @(negedge clk);
            drive_junk();
            in_valid = 1'b1;
            t_rows   = rows_t'(t);
            if (c < 16) begin
                in_data1 = det_elem_t'(m_mat[c]);
            end
            if (c < 8 * t) begin
                in_data2 = data_t'(x_mat[c]);
            end
            if (c < 64) begin
                w_q = data_t'(wq_mat[c]);
            end else if (c < 128) begin
                w_k = data_t'(wk_mat[c - 64]);
            end else begin
                w_v = data_t'(wv_mat[c - 128]);
            end
        end
        // the DUT is busy for all of the projection phase
        if (toggle) begin
            for (int c = 0; c < 24 * t; c++) begin
                @(negedge clk);
                drive_junk();
                in_valid = 1'($urandom_range(1));
                t_rows   = rows_t'($urandom_range(8, 1));
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // output monitor samples away from the rising edge
    always @(negedge clk) begin
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("out_valid is high while no output is expected");
            end else begin
                compare_result($sformatf("out_data[%0d] of frame %0d", run_len, frames_done),
                               out_data, exp_q.pop_front());
                run_len++;
            end
        end else begin
            compare_result("out_data outside the output window", out_data, result_t'(0));
            if (run_len != 0) begin
                check_count(frames_done, run_len, len_q.pop_front());
                run_len = 0;
                frames_done++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout after %0d cycles, the frames did not complete",
                               cycle_count));
        end
    end

    initial begin
        int t;
        void'($urandom(15));
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        t_rows   = '0;
        in_data1 = '0;
        in_data2 = '0;
        w_q      = '0;
        w_k      = '0;
        w_v      = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        // outputs must stay quiet over an idle stretch
        repeat (6) @(negedge clk);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            if (f < 8) begin
                t = T_ORDER[f];
            end else begin
                t = int'($urandom_range(8, 1));
            end
            if (f == 8) begin
                fill_relu();
            end else if (f == 9) begin
                fill_random();
                make_rows_equal();
            end else begin
                fill_random();
            end
            build_expected(t);
            run_frame(t, f % 2 == 1);
            wait (frames_done == f + 1);
        end
        repeat (4) @(negedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: verilog.f
sad_pkg.sv
sad_sequencer.sv
sad_input_buf.sv
sad_det.sv
sad_projection.sv
sad_attention.sv
sad_top.sv
tb_sad.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_sad
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
